//--- hdl/cpu_pkg.sv
package cpu_pkg;

    // ====================
    // Widths
    // ====================
    localparam int XLEN      = 16;
    localparam int ADDR_W    = 32;
    localparam int REG_IDX_W = 4;

    // Byte address of memory word 0
    localparam logic [ADDR_W-1:0] MEM_OFFSET = 32'h0000_1000;

    // ====================
    // Encodings
    // ====================
    // Instruction class in bits 15 to 13
    typedef enum logic [2:0] {
        OP_ARITH  = 3'b000,
        OP_CMPMUL = 3'b001,
        OP_LOAD   = 3'b010,
        OP_STORE  = 3'b011,
        OP_BEQ    = 3'b100,
        OP_JUMP   = 3'b101
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_MUL,
        ALU_INC,
        ALU_BRANCH,
        ALU_MEMADDR
    } alu_op_e;

    typedef enum logic [2:0] {
        S_FETCH,
        S_FETCH_WAIT,
        S_DECODE,
        S_EXEC,
        S_R_WB,
        S_MEM,
        S_MEM_WAIT,
        S_MEM_WB
    } cpu_state_e;

endpackage

//--- hdl/mem_req_if.sv
interface mem_req_if;

    // Request held stable until the response pulse
    logic                        req_valid;
    logic                        req_write;
    logic [cpu_pkg::ADDR_W-1:0]  req_addr;
    logic [cpu_pkg::XLEN-1:0]    req_wdata;

    // Single-cycle response
    logic                        rsp_valid;
    logic [cpu_pkg::XLEN-1:0]    rsp_rdata;

    modport ctrl (
        output req_valid, req_write, req_addr, req_wdata,
        input  rsp_valid, rsp_rdata
    );

    modport master (
        input  req_valid, req_write, req_addr, req_wdata,
        output rsp_valid, rsp_rdata
    );

endinterface

//--- hdl/alu.sv
module alu (
    input  cpu_pkg::alu_op_e                 i_op,
    input  logic signed [cpu_pkg::XLEN-1:0]  i_a,
    input  logic signed [cpu_pkg::XLEN-1:0]  i_b,
    output logic signed [cpu_pkg::XLEN-1:0]  o_result
);

    logic signed [cpu_pkg::XLEN-1:0] sum_ab;

    assign sum_ab = i_a + i_b;

    always_comb
    begin
        o_result = sum_ab;
        case (i_op)
            cpu_pkg::ALU_SUB: o_result = i_a - i_b;
            cpu_pkg::ALU_SLT:
            begin
                o_result    = '0;
                o_result[0] = (i_a < i_b);
            end
            // Low half of the product only
            cpu_pkg::ALU_MUL: o_result = i_a * i_b;
            cpu_pkg::ALU_INC: o_result = i_a + cpu_pkg::XLEN'(1);
            // Word index to byte address
            cpu_pkg::ALU_MEMADDR:
                o_result = (sum_ab <<< 1) + cpu_pkg::MEM_OFFSET[cpu_pkg::XLEN-1:0];
            default: o_result = sum_ab;
        endcase
    end

endmodule

//--- hdl/reg_file.sv
module reg_file (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [cpu_pkg::REG_IDX_W-1:0]    i_rs_idx,
    input  logic [cpu_pkg::REG_IDX_W-1:0]    i_rt_idx,
    input  logic                             i_wr_en,
    input  logic [cpu_pkg::REG_IDX_W-1:0]    i_wr_idx,
    input  logic signed [cpu_pkg::XLEN-1:0]  i_wr_data,
    output logic signed [cpu_pkg::XLEN-1:0]  o_rs_data,
    output logic signed [cpu_pkg::XLEN-1:0]  o_rt_data
);

    logic signed [cpu_pkg::XLEN-1:0] core_r [2**cpu_pkg::REG_IDX_W];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 2**cpu_pkg::REG_IDX_W; i++)
                core_r[i] <= '0;
        end
        else if (i_wr_en)
            core_r[i_wr_idx] <= i_wr_data;
    end

    // Both read ports sample every cycle
    always_ff @(posedge clk)
    begin
        o_rs_data <= core_r[i_rs_idx];
        o_rt_data <= core_r[i_rt_idx];
    end

endmodule

//--- hdl/axi_lite_master.sv
module axi_lite_master (
    input  logic                          clk,
    input  logic                          rst_n,
    mem_req_if.master                     mem,
    output logic                          o_awvalid,
    output logic [cpu_pkg::ADDR_W-1:0]    o_awaddr,
    input  logic                          i_awready,
    output logic                          o_wvalid,
    output logic [cpu_pkg::XLEN-1:0]      o_wdata,
    output logic [cpu_pkg::XLEN/8-1:0]    o_wstrb,
    input  logic                          i_wready,
    input  logic                          i_bvalid,
    output logic                          o_bready,
    output logic                          o_arvalid,
    output logic [cpu_pkg::ADDR_W-1:0]    o_araddr,
    input  logic                          i_arready,
    input  logic                          i_rvalid,
    input  logic [cpu_pkg::XLEN-1:0]      i_rdata,
    output logic                          o_rready
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_ADDR,
        M_RESP
    } master_state_e;

    master_state_e state;
    logic          aw_done;
    logic          w_done;

    // Full-word writes only
    assign o_wstrb = '1;

    // Channel finished when already dropped or accepted now
    assign aw_done = !o_awvalid || i_awready;
    assign w_done  = !o_wvalid || i_wready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state         <= M_IDLE;
            o_awvalid     <= 1'b0;
            o_wvalid      <= 1'b0;
            o_bready      <= 1'b0;
            o_arvalid     <= 1'b0;
            o_rready      <= 1'b0;
            mem.rsp_valid <= 1'b0;
        end
        else
        begin
            mem.rsp_valid <= 1'b0;
            case (state)
                M_IDLE:
                begin
                    // Request is still up during the response cycle
                    if (mem.req_valid && !mem.rsp_valid)
                    begin
                        o_awvalid <= mem.req_write;
                        o_wvalid  <= mem.req_write;
                        o_arvalid <= !mem.req_write;
                        state     <= M_ADDR;
                    end
                end
                M_ADDR:
                begin
                    if (mem.req_write)
                    begin
                        if (i_awready)
                            o_awvalid <= 1'b0;
                        if (i_wready)
                            o_wvalid <= 1'b0;
                        if (aw_done && w_done)
                        begin
                            o_bready <= 1'b1;
                            state    <= M_RESP;
                        end
                    end
                    else if (i_arready)
                    begin
                        o_arvalid <= 1'b0;
                        o_rready  <= 1'b1;
                        state     <= M_RESP;
                    end
                end
                M_RESP:
                begin
                    if (mem.req_write ? i_bvalid : i_rvalid)
                    begin
                        o_bready      <= 1'b0;
                        o_rready      <= 1'b0;
                        mem.rsp_valid <= 1'b1;
                        state         <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // Address, write data and read data
    always_ff @(posedge clk)
    begin
        if (state == M_IDLE && mem.req_valid)
        begin
            o_awaddr <= mem.req_addr;
            o_araddr <= mem.req_addr;
            o_wdata  <= mem.req_wdata;
        end
        if (state == M_RESP && o_rready && i_rvalid)
            mem.rsp_rdata <= i_rdata;
    end

endmodule

//--- hdl/cpu_ctrl.sv
module cpu_ctrl (
    input  logic                             clk,
    input  logic                             rst_n,
    output logic [cpu_pkg::REG_IDX_W-1:0]    o_rs_idx,
    output logic [cpu_pkg::REG_IDX_W-1:0]    o_rt_idx,
    input  logic signed [cpu_pkg::XLEN-1:0]  i_rs_data,
    input  logic signed [cpu_pkg::XLEN-1:0]  i_rt_data,
    output logic                             o_wr_en,
    output logic [cpu_pkg::REG_IDX_W-1:0]    o_wr_idx,
    output logic signed [cpu_pkg::XLEN-1:0]  o_wr_data,
    output cpu_pkg::alu_op_e                 o_alu_op,
    output logic signed [cpu_pkg::XLEN-1:0]  o_alu_a,
    output logic signed [cpu_pkg::XLEN-1:0]  o_alu_b,
    input  logic signed [cpu_pkg::XLEN-1:0]  i_alu_result,
    output logic                             o_io_stall,
    mem_req_if.ctrl                          mem
);

    cpu_pkg::cpu_state_e               state;
    cpu_pkg::cpu_state_e               state_nxt;
    logic                              inst_done;
    logic [cpu_pkg::XLEN-1:0]          pc;
    logic [cpu_pkg::XLEN-1:0]          ir;
    logic signed [cpu_pkg::XLEN-1:0]   alu_q;
    logic signed [cpu_pkg::XLEN-1:0]   load_q;

    cpu_pkg::opcode_e                  opcode;
    logic [cpu_pkg::REG_IDX_W-1:0]     rd;
    logic                              func;
    logic signed [cpu_pkg::XLEN-1:0]   imm_ext;

    // ====================
    // Instruction fields
    // ====================
    assign opcode   = cpu_pkg::opcode_e'(ir[15:13]);
    assign o_rs_idx = ir[12:9];
    assign o_rt_idx = ir[8:5];
    assign rd       = ir[4:1];
    assign func     = ir[0];
    assign imm_ext  = {{(cpu_pkg::XLEN-5){ir[4]}}, ir[4:0]};

    // ====================
    // Next state
    // ====================
    always_comb
    begin
        state_nxt = state;
        inst_done = 1'b0;
        case (state)
            cpu_pkg::S_FETCH:      state_nxt = cpu_pkg::S_FETCH_WAIT;
            cpu_pkg::S_FETCH_WAIT: if (mem.rsp_valid) state_nxt = cpu_pkg::S_DECODE;
            cpu_pkg::S_DECODE:
            begin
                // J and unknown opcodes finish here
                if (opcode inside {cpu_pkg::OP_ARITH, cpu_pkg::OP_CMPMUL, cpu_pkg::OP_LOAD,
                                   cpu_pkg::OP_STORE, cpu_pkg::OP_BEQ})
                    state_nxt = cpu_pkg::S_EXEC;
                else
                begin
                    state_nxt = cpu_pkg::S_FETCH;
                    inst_done = 1'b1;
                end
            end
            cpu_pkg::S_EXEC:
            begin
                if (opcode == cpu_pkg::OP_BEQ)
                begin
                    state_nxt = cpu_pkg::S_FETCH;
                    inst_done = 1'b1;
                end
                else if (opcode == cpu_pkg::OP_LOAD || opcode == cpu_pkg::OP_STORE)
                    state_nxt = cpu_pkg::S_MEM;
                else
                    state_nxt = cpu_pkg::S_R_WB;
            end
            cpu_pkg::S_MEM:        state_nxt = cpu_pkg::S_MEM_WAIT;
            cpu_pkg::S_MEM_WAIT:   if (mem.rsp_valid) state_nxt = cpu_pkg::S_MEM_WB;
            default:
            begin
                state_nxt = cpu_pkg::S_FETCH;
                inst_done = 1'b1;
            end
        endcase
    end

    // ====================
    // Control registers
    // ====================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state         <= cpu_pkg::S_FETCH;
            pc            <= '0;
            ir            <= '0;
            mem.req_valid <= 1'b0;
            o_io_stall    <= 1'b1;
        end
        else
        begin
            state      <= state_nxt;
            o_io_stall <= !inst_done;
            case (state)
                cpu_pkg::S_FETCH:
                begin
                    pc            <= i_alu_result;
                    mem.req_valid <= 1'b1;
                end
                cpu_pkg::S_FETCH_WAIT:
                begin
                    if (mem.rsp_valid)
                    begin
                        ir            <= mem.rsp_rdata;
                        mem.req_valid <= 1'b0;
                    end
                end
                cpu_pkg::S_DECODE:
                begin
                    if (opcode == cpu_pkg::OP_JUMP)
                        pc <= {{(cpu_pkg::XLEN-13){1'b0}}, ir[12:0]};
                end
                cpu_pkg::S_EXEC:
                begin
                    // pc was already advanced during fetch
                    if (opcode == cpu_pkg::OP_BEQ && i_rs_data == i_rt_data)
                        pc <= i_alu_result;
                end
                cpu_pkg::S_MEM:      mem.req_valid <= 1'b1;
                cpu_pkg::S_MEM_WAIT: if (mem.rsp_valid) mem.req_valid <= 1'b0;
                default: ;
            endcase
        end
    end

    // Request fields and datapath results
    always_ff @(posedge clk)
    begin
        if (state == cpu_pkg::S_FETCH)
        begin
            mem.req_write <= 1'b0;
            mem.req_addr  <= cpu_pkg::MEM_OFFSET
                             + {{(cpu_pkg::ADDR_W-cpu_pkg::XLEN-1){1'b0}}, pc, 1'b0};
        end
        else if (state == cpu_pkg::S_MEM)
        begin
            mem.req_write <= (opcode == cpu_pkg::OP_STORE);
            mem.req_addr  <= {{(cpu_pkg::ADDR_W-cpu_pkg::XLEN){1'b0}}, alu_q};
            mem.req_wdata <= i_rt_data;
        end
        if (state == cpu_pkg::S_EXEC)
            alu_q <= i_alu_result;
        if (state == cpu_pkg::S_MEM_WAIT && mem.rsp_valid)
            load_q <= mem.rsp_rdata;
    end

    // ====================
    // ALU operand select
    // ====================
    always_comb
    begin
        o_alu_op = cpu_pkg::ALU_ADD;
        o_alu_a  = i_rs_data;
        o_alu_b  = i_rt_data;
        if (state == cpu_pkg::S_FETCH)
        begin
            o_alu_op = cpu_pkg::ALU_INC;
            o_alu_a  = pc;
        end
        else
        begin
            case (opcode)
                cpu_pkg::OP_ARITH:  o_alu_op = func ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                cpu_pkg::OP_CMPMUL: o_alu_op = func ? cpu_pkg::ALU_MUL : cpu_pkg::ALU_SLT;
                cpu_pkg::OP_LOAD, cpu_pkg::OP_STORE:
                begin
                    o_alu_op = cpu_pkg::ALU_MEMADDR;
                    o_alu_b  = imm_ext;
                end
                cpu_pkg::OP_BEQ:
                begin
                    o_alu_op = cpu_pkg::ALU_BRANCH;
                    o_alu_a  = pc;
                    o_alu_b  = imm_ext;
                end
                default: ;
            endcase
        end
    end

    // Write-back to rd for arithmetic and to rt for loads
    assign o_wr_en   = (state == cpu_pkg::S_R_WB)
                       || (state == cpu_pkg::S_MEM_WB && opcode == cpu_pkg::OP_LOAD);
    assign o_wr_idx  = (state == cpu_pkg::S_R_WB) ? rd : o_rt_idx;
    assign o_wr_data = (state == cpu_pkg::S_R_WB) ? alu_q : load_q;

endmodule

//--- hdl/cpu_top.sv
module cpu_top (
    input  logic                             clk,
    input  logic                             rst_n,
    output logic                             o_io_stall,
    // Write address channel
    output logic                             o_awvalid,
    output logic [cpu_pkg::ADDR_W-1:0]       o_awaddr,
    input  logic                             i_awready,
    // Write data channel
    output logic                             o_wvalid,
    output logic [cpu_pkg::XLEN-1:0]         o_wdata,
    output logic [cpu_pkg::XLEN/8-1:0]       o_wstrb,
    input  logic                             i_wready,
    // Write response channel
    input  logic                             i_bvalid,
    input  logic [1:0]                       i_bresp,
    output logic                             o_bready,
    // Read address channel
    output logic                             o_arvalid,
    output logic [cpu_pkg::ADDR_W-1:0]       o_araddr,
    input  logic                             i_arready,
    // Read data channel
    input  logic                             i_rvalid,
    input  logic [cpu_pkg::XLEN-1:0]         i_rdata,
    input  logic [1:0]                       i_rresp,
    output logic                             o_rready
);

    logic [cpu_pkg::REG_IDX_W-1:0]     rs_idx;
    logic [cpu_pkg::REG_IDX_W-1:0]     rt_idx;
    logic signed [cpu_pkg::XLEN-1:0]   rs_data;
    logic signed [cpu_pkg::XLEN-1:0]   rt_data;
    logic                              wr_en;
    logic [cpu_pkg::REG_IDX_W-1:0]     wr_idx;
    logic signed [cpu_pkg::XLEN-1:0]   wr_data;
    cpu_pkg::alu_op_e                  alu_op;
    logic signed [cpu_pkg::XLEN-1:0]   alu_a;
    logic signed [cpu_pkg::XLEN-1:0]   alu_b;
    logic signed [cpu_pkg::XLEN-1:0]   alu_result;

    mem_req_if mem_bus ();

    cpu_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .o_rs_idx     (rs_idx),
        .o_rt_idx     (rt_idx),
        .i_rs_data    (rs_data),
        .i_rt_data    (rt_data),
        .o_wr_en      (wr_en),
        .o_wr_idx     (wr_idx),
        .o_wr_data    (wr_data),
        .o_alu_op     (alu_op),
        .o_alu_a      (alu_a),
        .o_alu_b      (alu_b),
        .i_alu_result (alu_result),
        .o_io_stall   (o_io_stall),
        .mem          (mem_bus)
    );

    reg_file u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_rs_idx  (rs_idx),
        .i_rt_idx  (rt_idx),
        .i_wr_en   (wr_en),
        .i_wr_idx  (wr_idx),
        .i_wr_data (wr_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    alu u_alu (
        .i_op     (alu_op),
        .i_a      (alu_a),
        .i_b      (alu_b),
        .o_result (alu_result)
    );

    axi_lite_master u_axi (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem       (mem_bus),
        .o_awvalid (o_awvalid),
        .o_awaddr  (o_awaddr),
        .i_awready (i_awready),
        .o_wvalid  (o_wvalid),
        .o_wdata   (o_wdata),
        .o_wstrb   (o_wstrb),
        .i_wready  (i_wready),
        .i_bvalid  (i_bvalid),
        .o_bready  (o_bready),
        .o_arvalid (o_arvalid),
        .o_araddr  (o_araddr),
        .i_arready (i_arready),
        .i_rvalid  (i_rvalid),
        .i_rdata   (i_rdata),
        .o_rready  (o_rready)
    );

endmodule

//--- sim/tb_cpu.sv
module tb_cpu;

    localparam int          MEM_WORDS  = 64;
    localparam logic [31:0] MEM_BASE   = 32'h0000_1000;
    localparam int          PROG_LEN   = 26;
    localparam int          NUM_STORES = 8;
    localparam int          EXP_INSTR  = 22;
    localparam int          MAX_CYCLES = EXP_INSTR * 30;
    localparam int          BASE       = 48;

    localparam logic [2:0] OPC_ARITH  = 3'd0;
    localparam logic [2:0] OPC_CMPMUL = 3'd1;
    localparam logic [2:0] OPC_LOAD   = 3'd2;
    localparam logic [2:0] OPC_STORE  = 3'd3;
    localparam logic [2:0] OPC_BEQ    = 3'd4;
    localparam logic [2:0] OPC_JUMP   = 3'd5;

    logic        clk;
    logic        rst_n;
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [15:0] rdata;
    logic [1:0]  rresp;
    logic        io_stall;
    logic        awvalid;
    logic [31:0] awaddr;
    logic        wvalid;
    logic [15:0] wdata;
    logic [1:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [31:0] araddr;
    logic        rready;

    logic [15:0] mem_words [0:MEM_WORDS-1];
    logic [15:0] prog [0:PROG_LEN-1];
    logic [31:0] exp_addr [0:NUM_STORES-1];
    logic [15:0] exp_data [0:NUM_STORES-1];

    integer      seed = 32'hffcd;
    int          instr_count;
    int          cycle_count;
    int          store_idx;
    int          ar_dly;
    int          r_dly;
    int          aw_dly;
    int          w_dly;
    int          b_dly;
    logic        rd_pend;
    logic        aw_got;
    logic        w_got;
    logic        aw_wait;
    logic        w_wait;
    logic        first_read;
    logic [5:0]  rd_word;
    logic [5:0]  wr_word;
    logic [31:0] aw_addr_q;
    logic [15:0] w_data_q;

    cpu_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .o_io_stall (io_stall),
        .o_awvalid  (awvalid),
        .o_awaddr   (awaddr),
        .i_awready  (awready),
        .o_wvalid   (wvalid),
        .o_wdata    (wdata),
        .o_wstrb    (wstrb),
        .i_wready   (wready),
        .i_bvalid   (bvalid),
        .i_bresp    (bresp),
        .o_bready   (bready),
        .o_arvalid  (arvalid),
        .o_araddr   (araddr),
        .i_arready  (arready),
        .i_rvalid   (rvalid),
        .i_rdata    (rdata),
        .i_rresp    (rresp),
        .o_rready   (rready)
    );

    always #2 clk = ~clk;

    // ====================
    // Encoders and helpers
    // ====================
    function automatic logic [15:0] enc_r(logic [2:0] op, int rs, int rt, int rd, bit f);
        return {op, 4'(rs), 4'(rt), 4'(rd), f};
    endfunction

    function automatic logic [15:0] enc_i(logic [2:0] op, int rs, int rt, int imm);
        return {op, 4'(rs), 4'(rt), 5'(imm)};
    endfunction

    function automatic logic [15:0] enc_j(int target);
        return {OPC_JUMP, 13'(target)};
    endfunction

    function automatic logic [31:0] byte_addr(int word);
        return MEM_BASE + 32'(word * 2);
    endfunction

    function int rand_delay();
        return $random(seed) & 3;
    endfunction

    task automatic stop_on_error();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_failure(string msg);
        $display("%s", msg);
        stop_on_error();
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic lookup_word(logic [31:0] addr, output logic [5:0] idx);
        if (addr < MEM_BASE || addr >= byte_addr(MEM_WORDS) || addr[0])
            report_failure($sformatf("Bus address 0x%h is outside the memory model", addr));
        idx = 6'((addr - MEM_BASE) >> 1);
    endtask

    task automatic check_bus_idle();
        check_value("o_awvalid", 32'(awvalid), 32'd0);
        check_value("o_wvalid", 32'(wvalid), 32'd0);
        check_value("o_arvalid", 32'(arvalid), 32'd0);
        check_value("o_bready", 32'(bready), 32'd0);
        check_value("o_rready", 32'(rready), 32'd0);
        check_value("o_io_stall", 32'(io_stall), 32'd1);
    endtask

    // ====================
    // Program and tables
    // ====================
    task automatic build_tables();
        logic [15:0] d2;
        logic [15:0] d3;
        logic [15:0] d4;
        logic [15:0] d_neg;
        d2    = 16'h1234;
        d3    = 16'hff00;
        d4    = 16'h0123;
        d_neg = 16'h0bad;
        prog[0]  = enc_j(2);
        // Base pointer word skipped by the jump
        prog[1]  = 16'(BASE);
        prog[2]  = enc_i(OPC_LOAD, 0, 1, 1);
        prog[3]  = enc_i(OPC_LOAD, 1, 2, 0);
        prog[4]  = enc_i(OPC_LOAD, 1, 3, 1);
        prog[5]  = enc_i(OPC_LOAD, 1, 4, 2);
        prog[6]  = enc_r(OPC_ARITH, 2, 3, 5, 1'b0);
        prog[7]  = enc_i(OPC_STORE, 1, 5, 8);
        prog[8]  = enc_r(OPC_ARITH, 3, 4, 6, 1'b1);
        prog[9]  = enc_i(OPC_STORE, 1, 6, 9);
        prog[10] = enc_r(OPC_CMPMUL, 3, 4, 7, 1'b0);
        prog[11] = enc_i(OPC_STORE, 1, 7, 10);
        prog[12] = enc_r(OPC_CMPMUL, 4, 3, 8, 1'b0);
        prog[13] = enc_i(OPC_STORE, 1, 8, 11);
        prog[14] = enc_r(OPC_CMPMUL, 2, 4, 9, 1'b1);
        prog[15] = enc_i(OPC_STORE, 1, 9, 12);
        prog[16] = enc_i(OPC_LOAD, 1, 10, -2);
        prog[17] = enc_i(OPC_STORE, 1, 10, -16);
        // Taken branch over a poisoning store
        prog[18] = enc_i(OPC_BEQ, 2, 2, 1);
        prog[19] = enc_i(OPC_STORE, 1, 2, 13);
        prog[20] = enc_i(OPC_BEQ, 2, 3, 1);
        prog[21] = enc_i(OPC_STORE, 1, 3, 13);
        prog[22] = enc_j(24);
        prog[23] = enc_i(OPC_STORE, 1, 2, 14);
        prog[24] = enc_i(OPC_STORE, 1, 4, 14);
        prog[25] = enc_j(25);

        for (int i = 0; i < MEM_WORDS; i++)
            mem_words[6'(i)] = 16'(i * 40503) ^ 16'h5a5a;
        for (int i = 0; i < PROG_LEN; i++)
            mem_words[6'(i)] = prog[i];
        mem_words[6'(BASE - 2)] = d_neg;
        mem_words[6'(BASE)]     = d2;
        mem_words[6'(BASE + 1)] = d3;
        mem_words[6'(BASE + 2)] = d4;

        exp_addr[0] = byte_addr(BASE + 8);
        exp_data[0] = d2 + d3;
        exp_addr[1] = byte_addr(BASE + 9);
        exp_data[1] = d3 - d4;
        exp_addr[2] = byte_addr(BASE + 10);
        exp_data[2] = 16'($signed(d3) < $signed(d4));
        exp_addr[3] = byte_addr(BASE + 11);
        exp_data[3] = 16'($signed(d4) < $signed(d3));
        exp_addr[4] = byte_addr(BASE + 12);
        exp_data[4] = 16'(d2 * d4);
        exp_addr[5] = byte_addr(BASE - 16);
        exp_data[5] = d_neg;
        exp_addr[6] = byte_addr(BASE + 13);
        exp_data[6] = d3;
        exp_addr[7] = byte_addr(BASE + 14);
        exp_data[7] = d4;
    endtask

    // ====================
    // AXI4-Lite memory model
    // ====================
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (!io_stall)
                instr_count++;

            // Read address and data
            if (arready)
            begin
                arready = 1'b0;
                rd_pend = 1'b1;
            end
            else if (arvalid && !rd_pend)
            begin
                if (ar_dly == 0)
                begin
                    if (first_read)
                        check_value("o_araddr", araddr, MEM_BASE);
                    first_read = 1'b0;
                    lookup_word(araddr, rd_word);
                    arready = 1'b1;
                    ar_dly  = rand_delay();
                end
                else
                    ar_dly--;
            end
            if (rvalid)
                rvalid = 1'b0;
            else if (rd_pend && rready)
            begin
                if (r_dly == 0)
                begin
                    rdata   = mem_words[rd_word];
                    rvalid  = 1'b1;
                    rd_pend = 1'b0;
                    r_dly   = rand_delay();
                end
                else
                    r_dly--;
            end

            // Write address handled apart from W
            if (awready)
            begin
                awready = 1'b0;
                aw_got  = 1'b1;
            end
            else if (awvalid && !aw_got)
            begin
                if (aw_dly == 0)
                begin
                    awready   = 1'b1;
                    aw_addr_q = awaddr;
                    aw_wait   = 1'b0;
                    aw_dly    = rand_delay();
                end
                else
                begin
                    aw_dly--;
                    aw_wait = 1'b1;
                end
            end
            else if (aw_wait)
                report_failure("awvalid dropped before the address was accepted");

            if (wready)
            begin
                wready = 1'b0;
                w_got  = 1'b1;
            end
            else if (wvalid && !w_got)
            begin
                if (w_dly == 0)
                begin
                    check_value("o_wstrb", 32'(wstrb), 32'h3);
                    wready   = 1'b1;
                    w_data_q = wdata;
                    w_wait   = 1'b0;
                    w_dly    = rand_delay();
                end
                else
                begin
                    w_dly--;
                    w_wait = 1'b1;
                end
            end
            else if (w_wait)
                report_failure("wvalid dropped before the data was accepted");

            // Response once both halves of the store are in
            if (bvalid)
                bvalid = 1'b0;
            else if (aw_got && w_got && bready)
            begin
                if (b_dly == 0)
                begin
                    if (store_idx >= NUM_STORES)
                        report_failure("A store appeared after the last expected store");
                    check_value("o_awaddr", aw_addr_q, exp_addr[3'(store_idx)]);
                    check_value("o_wdata", 32'(w_data_q), 32'(exp_data[3'(store_idx)]));
                    lookup_word(aw_addr_q, wr_word);
                    mem_words[wr_word] = w_data_q;
                    store_idx++;
                    // One instruction short while the last store is in flight
                    if (store_idx == NUM_STORES)
                        check_value("o_io_stall pulses", 32'(instr_count), 32'(EXP_INSTR - 1));
                    aw_got = 1'b0;
                    w_got  = 1'b0;
                    bvalid = 1'b1;
                    b_dly  = rand_delay();
                end
                else
                    b_dly--;
            end
        end
    end

    always @(posedge clk)
    begin
        if (rst_n)
        begin
            cycle_count++;
            if (cycle_count > MAX_CYCLES)
                report_failure($sformatf("Timeout with %0d of %0d stores seen, stores are missing",
                                         store_idx, NUM_STORES));
        end
    end

    initial
    begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        awready     = 1'b0;
        wready      = 1'b0;
        bvalid      = 1'b0;
        bresp       = 2'b00;
        arready     = 1'b0;
        rvalid      = 1'b0;
        rdata       = '0;
        rresp       = 2'b00;
        instr_count = 0;
        cycle_count = 0;
        store_idx   = 0;
        rd_pend     = 1'b0;
        aw_got      = 1'b0;
        w_got       = 1'b0;
        aw_wait     = 1'b0;
        w_wait      = 1'b0;
        first_read  = 1'b1;
        build_tables();
        ar_dly = rand_delay();
        r_dly  = rand_delay();
        aw_dly = rand_delay();
        w_dly  = rand_delay();
        b_dly  = rand_delay();

        repeat (16)
        begin
            @(negedge clk);
            check_bus_idle();
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_bus_idle();

        while (store_idx < NUM_STORES || instr_count < EXP_INSTR)
            @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- all.f
hdl/cpu_pkg.sv
hdl/mem_req_if.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/axi_lite_master.sv
hdl/cpu_ctrl.sv
hdl/cpu_top.sv
sim/tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_cpu
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP)

clean:
	rm -rf $(OBJ_DIR)
